/* bench/eeprom_ctl_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctl_assertions
(
    input wire CLK,
    input wire RESET,
    input wire wr,
    input wire busy,
    input wire done,
    input wire scl,
    input wire sda
);

    int fail_count = 0;

    bus_idle: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> scl && (sda === 1'b1))
    else
    begin
        fail_count++;
        $error("scl or sda not high while idle");
    end

    done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
    else
    begin
        fail_count++;
        $error("done wider than one cycle");
    end

    // decode registers the strobe first, busy follows a cycle later
    wr_starts: assert property (@(posedge CLK) disable iff (RESET) wr && !busy |-> ##2 busy)
    else
    begin
        fail_count++;
        $error("write strobe while idle did not raise busy");
    end

endmodule

bind eeprom_ctl_top eeprom_ctl_assertions u_assert
(
    .CLK   (CLK),
    .RESET (RESET),
    .wr    (wr),
    .busy  (busy),
    .done  (done),
    .scl   (scl),
    .sda   (sda)
);

`default_nettype wire

/* bench/eeprom_ctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctl_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int N_TRANS      = 88;  // 40 writes, 40 reads, 8 directed
    localparam int MAX_LATENCY  = 200;

    logic                          CLK;
    logic                          RESET;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [7:0]                    wdata;
    logic [7:0]                    rdata;
    logic                          done;
    logic                          ack_err;
    logic                          busy;
    logic                          scl;
    logic                          ack_enable;
    wire                           sda;

    logic [7:0]                    ref_mem [0:(1 << eeprom_pkg::ADDR_W) - 1];
    logic [eeprom_pkg::ADDR_W-1:0] written_q [$];
    logic [31:0]                   lfsr;
    logic [7:0]                    last_rdata;
    int                            done_count = 0;

    pullup (sda);

    eeprom_ctl_top uut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .done    (done),
        .ack_err (ack_err),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model slave
    (
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(negedge CLK)
        if (done === 1'b1)
            done_count++;

    always @(negedge CLK)
        if (uut.u_assert.fail_count != 0)
        begin
            $display("a concurrent assertion on the DUT failed");
            fail_now();
        end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_now();
        $display("Test failures found");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic strobe(input logic w, input logic r,
                          input logic [eeprom_pkg::ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge CLK);
        #2;
        wr    = w;
        rd    = r;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done();
        int n = 0;
        @(negedge CLK);
        while (done !== 1'b1)
        begin
            if (n == MAX_LATENCY)
            begin
                $display("no done within %0d cycles of the strobe", MAX_LATENCY);
                fail_now();
            end
            n++;
            @(negedge CLK);
        end
    endtask

    task automatic wait_busy();
        int n = 0;
        @(negedge CLK);
        while (busy !== 1'b1)
        begin
            if (n == 4)
            begin
                $display("busy did not rise after an accepted strobe");
                fail_now();
            end
            n++;
            @(negedge CLK);
        end
    endtask

    // a write leaves rdata as the last read put it
    task automatic do_write(input logic [eeprom_pkg::ADDR_W-1:0] a, input logic [7:0] d,
                            input logic also_rd, input logic exp_err);
        strobe(1'b1, also_rd, a, d);
        wait_done();
        check_bit("ack_err", ack_err, exp_err);
        check_byte("rdata", rdata, last_rdata);
        if (!exp_err)
            ref_mem[a] = d;
    endtask

    task automatic do_read(input logic [eeprom_pkg::ADDR_W-1:0] a, input logic exp_err);
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_done();
        check_bit("ack_err", ack_err, exp_err);
        last_rdata = exp_err ? 8'hFF : ref_mem[a]; // released bus reads as ones
        check_byte("rdata", rdata, last_rdata);
    endtask

    initial
    begin
        #(CLK_PERIOD * (N_TRANS * MAX_LATENCY + RESET_CYCLES + 20));
        $display("timeout: the run did not finish in its cycle budget");
        fail_now();
    end

    initial
    begin
        logic [31:0]                   r;
        logic [eeprom_pkg::ADDR_W-1:0] a;
        logic [eeprom_pkg::ADDR_W-1:0] b;
        logic [7:0]                    d;
        int                            base;

        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        ack_enable = 1'b1;
        lfsr       = 32'h3094_ecf2;
        for (int i = 0; i < (1 << eeprom_pkg::ADDR_W); i++)
            ref_mem[i] = 8'hFF;              // blank device
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        RESET = 1'b0;

        @(negedge CLK);
        check_bit("scl", scl, 1'b1);
        check_bit("sda", sda, 1'b1);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("ack_err", ack_err, 1'b0);

        repeat (40)
        begin
            rand_bits(eeprom_pkg::ADDR_W, r);
            a = r[eeprom_pkg::ADDR_W-1:0];
            rand_bits(8, r);
            do_write(a, r[7:0], 1'b0, 1'b0);
            written_q.push_back(a);
        end
        repeat (40)
        begin
            rand_bits(1, r);
            if (r[0])
            begin
                rand_bits(6, r);
                a = written_q[r[5:0] % written_q.size()];
            end
            else
            begin
                rand_bits(eeprom_pkg::ADDR_W, r);
                a = r[eeprom_pkg::ADDR_W-1:0];
            end
            do_read(a, 1'b0);
        end

        // strobes during a transfer
        @(posedge CLK);
        base = done_count;
        a = written_q[0];
        b = written_q[1];
        rand_bits(8, r);
        d = r[7:0];
        strobe(1'b1, 1'b0, a, d);
        wait_busy();
        strobe(1'b1, 1'b0, b, ~ref_mem[b]);
        strobe(1'b0, 1'b1, b, 8'h00);
        wait_done();
        ref_mem[a] = d;
        check_bit("ack_err", ack_err, 1'b0);
        check_byte("rdata", rdata, last_rdata);
        repeat (3)
        begin
            @(negedge CLK);
            check_bit("busy", busy, 1'b0);
        end
        check_count("done_count", done_count, base + 1);
        do_read(a, 1'b0);
        do_read(b, 1'b0);
        @(posedge CLK);
        check_count("done_count", done_count, base + 3);

        // slave gone quiet
        a = written_q[2];
        @(posedge CLK);
        #2;
        ack_enable = 1'b0;
        do_write(a, ~ref_mem[a], 1'b0, 1'b1);
        do_read(a, 1'b1);
        @(posedge CLK);
        #2;
        ack_enable = 1'b1;
        do_read(a, 1'b0);

        rand_bits(eeprom_pkg::ADDR_W, r);
        a = r[eeprom_pkg::ADDR_W-1:0];
        rand_bits(8, r);
        do_write(a, r[7:0], 1'b1, 1'b0);   // wr and rd together
        do_read(a, 1'b0);

        @(negedge CLK);
        if (uut.u_assert.fail_count == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures", uut.u_assert.fail_count);
            fail_now();
        end
    end

endmodule

`default_nettype wire

/* bench/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_model
(
    input  wire  scl,
    inout  wire  sda,
    input  logic ack_enable
);

    localparam int PH_IDLE = 0;
    localparam int PH_RX   = 1;
    localparam int PH_ACK  = 2;
    localparam int PH_TX   = 3;
    localparam int PH_MACK = 4;

    logic [7:0]  mem [0:2047];
    logic        drive_low;
    logic        scl_q;
    logic        sda_q;
    logic        scl_s;
    logic        sda_s;
    logic [7:0]  shreg;
    logic [10:0] ptr;
    logic        rnw;
    int          phase;
    int          nbits;
    int          byte_idx;

    assign sda = drive_low ? 1'b0 : 1'bz;

    task automatic take_byte();
        phase = PH_ACK;
        drive_low = 1'b1;
        case (byte_idx)
            0:
                if (shreg[7:4] == 4'b1010 && ack_enable)
                begin
                    rnw       = shreg[0];
                    ptr[10:8] = shreg[3:1];
                end
                else
                begin
                    phase     = PH_IDLE; // not addressed, stay off the bus
                    drive_low = 1'b0;
                end
            1: ptr[7:0] = shreg;
            2: mem[ptr] = shreg;
            default:
            begin
                phase     = PH_IDLE; // no page writes
                drive_low = 1'b0;
            end
        endcase
        byte_idx++;
    endtask

    task automatic scl_fell();
        case (phase)
            PH_RX:
                if (nbits == 8)
                    take_byte();
            PH_ACK:
                if (rnw)
                begin
                    shreg     = mem[ptr];
                    drive_low = !shreg[7];
                    nbits     = 1;
                    phase     = PH_TX;
                end
                else
                begin
                    drive_low = 1'b0;
                    nbits     = 0;
                    phase     = PH_RX;
                end
            PH_TX:
                if (nbits == 8)
                begin
                    drive_low = 1'b0;    // master acks or nacks now
                    phase     = PH_MACK;
                end
                else
                begin
                    drive_low = !shreg[7-nbits];
                    nbits++;
                end
            PH_MACK:
            begin
                ptr   = ptr + 11'd1;
                phase = PH_IDLE;         // single byte reads only
            end
            default: ;
        endcase
    endtask

    // oversampled between clock edges so both lines are settled
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        drive_low = 1'b0;
        phase     = PH_IDLE;
        nbits     = 0;
        byte_idx  = 0;
        rnw       = 1'b0;
        ptr       = '0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        #0.5;
        forever
        begin
            scl_s = (scl !== 1'b0);
            sda_s = (sda !== 1'b0);
            if (scl_q && scl_s && sda_q && !sda_s)
            begin
                phase     = PH_RX;     // start or repeated start
                nbits     = 0;
                byte_idx  = 0;
                drive_low = 1'b0;
            end
            else if (scl_q && scl_s && !sda_q && sda_s)
            begin
                phase     = PH_IDLE;   // stop
                drive_low = 1'b0;
            end
            else if (!scl_q && scl_s && phase == PH_RX && nbits < 8)
            begin
                shreg = {shreg[6:0], sda_s};
                nbits++;
            end
            else if (scl_q && !scl_s)
                scl_fell();
            scl_q = scl_s;
            sda_q = sda_s;
            #1;
        end
    end

endmodule

`default_nettype wire

/* hdl/eeprom_bit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface eeprom_bit_if;

    logic              bit_valid; // at the scl high sample point
    eeprom_pkg::slot_e bit_slot;
    logic              bit_val;
    logic              xfer_end;  // one cycle after stop
    eeprom_pkg::op_e   xfer_op;

    modport execute
    (
        output bit_valid, bit_slot, bit_val, xfer_end, xfer_op
    );

    modport result
    (
        input bit_valid, bit_slot, bit_val, xfer_end, xfer_op
    );

endinterface

`default_nettype wire

/* hdl/eeprom_bus_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_bus_execute
(
    input  logic          CLK,
    input  logic          RESET,
    eeprom_cmd_if.execute cmd,
    eeprom_bit_if.execute bits,
    output logic          busy,
    output logic          scl,
    output logic          sda_low,
    input  logic          sda_in
);

    logic [3:0]             state;
    logic [3:0]             pre;   // quarter prescaler
    logic [1:0]             q;     // quarter within bit time
    logic [3:0]             bcnt;  // bit in byte, 8 is the ack slot
    logic [7:0]             sh;
    logic                   tick;
    logic                   byte_out;
    logic                   ack_slot;
    logic                   bit_end;
    eeprom_pkg::op_e        op_q;
    eeprom_pkg::ctrl_byte_u ctrl_q;
    eeprom_pkg::ctrl_byte_u rd_ctrl;
    logic [7:0]             addr_q;
    logic [7:0]             wdata_q;

    assign tick     = (pre == 4'(eeprom_pkg::QTR - 1));
    assign bit_end  = tick && (q == 2'd3);
    assign byte_out = (state == eeprom_pkg::ST_CTRL) || (state == eeprom_pkg::ST_ADDR) ||
                      (state == eeprom_pkg::ST_RDCTRL) || (state == eeprom_pkg::ST_WDATA);
    assign ack_slot = byte_out && (bcnt == 4'd8);

    always_comb
    begin
        rd_ctrl = ctrl_q;
        rd_ctrl.fields.rnw = 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_pkg::ST_IDLE;
            pre   <= '0;
            q     <= '0;
            bcnt  <= '0;
        end
        else if (state == eeprom_pkg::ST_IDLE)
        begin
            pre  <= '0;
            q    <= '0;
            bcnt <= '0;
            if (cmd.cmd_valid)
                state <= eeprom_pkg::ST_START;
        end
        else if (state == eeprom_pkg::ST_END)
            state <= eeprom_pkg::ST_IDLE;
        else if (!tick)
            pre <= pre + 4'd1;
        else
        begin
            pre <= '0;
            q   <= q + 2'd1;
            if (q == 2'd3)
            begin
                bcnt <= bcnt + 4'd1;
                case (state)
                    eeprom_pkg::ST_START:
                    begin
                        state <= eeprom_pkg::ST_CTRL;
                        bcnt  <= '0;
                    end
                    eeprom_pkg::ST_CTRL, eeprom_pkg::ST_RDCTRL:
                        if (bcnt == 4'd8)
                        begin
                            state <= (state == eeprom_pkg::ST_CTRL) ? eeprom_pkg::ST_ADDR
                                                                    : eeprom_pkg::ST_DATA_IN;
                            bcnt  <= '0;
                        end
                    eeprom_pkg::ST_ADDR:
                        if (bcnt == 4'd8)
                        begin
                            state <= (op_q == eeprom_pkg::OP_READ) ? eeprom_pkg::ST_RESTART
                                                                  : eeprom_pkg::ST_WDATA;
                            bcnt  <= '0;
                        end
                    eeprom_pkg::ST_RESTART:
                    begin
                        state <= eeprom_pkg::ST_RDCTRL;
                        bcnt  <= '0;
                    end
                    eeprom_pkg::ST_DATA_IN:
                        if (bcnt == 4'd7)
                            state <= eeprom_pkg::ST_NACK;
                    eeprom_pkg::ST_WDATA:
                        if (bcnt == 4'd8)
                            state <= eeprom_pkg::ST_STOP;
                    eeprom_pkg::ST_NACK:  state <= eeprom_pkg::ST_STOP;
                    eeprom_pkg::ST_STOP:  state <= eeprom_pkg::ST_END;
                    default:              state <= eeprom_pkg::ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::ST_IDLE && cmd.cmd_valid)
        begin
            op_q    <= cmd.op;
            ctrl_q  <= cmd.ctrl;
            addr_q  <= cmd.word_addr;
            wdata_q <= cmd.wdata;
        end
        if (bit_end)
        begin
            case (state)
                eeprom_pkg::ST_START:   sh <= ctrl_q.raw;
                eeprom_pkg::ST_CTRL:    sh <= (bcnt == 4'd8) ? addr_q : {sh[6:0], 1'b0};
                eeprom_pkg::ST_ADDR:    sh <= (bcnt == 4'd8) ? wdata_q : {sh[6:0], 1'b0};
                eeprom_pkg::ST_RESTART: sh <= rd_ctrl.raw;
                default:                sh <= {sh[6:0], 1'b0};
            endcase
        end
    end

    // sda moves in q0 with scl low, scl is high in q1 and q2
    always_comb
    begin
        scl     = 1'b1;
        sda_low = 1'b0;
        case (state)
            eeprom_pkg::ST_IDLE, eeprom_pkg::ST_END:
            begin
                scl     = 1'b1;
                sda_low = 1'b0;
            end
            eeprom_pkg::ST_START:
            begin
                scl     = (q != 2'd3);
                sda_low = q[1];      // falls in q2 while scl high
            end
            eeprom_pkg::ST_RESTART:
            begin
                scl     = (q == 2'd1) || (q == 2'd2);
                sda_low = q[1];
            end
            eeprom_pkg::ST_STOP:
            begin
                scl     = (q != 2'd0);
                sda_low = !q[1];     // rises in q2 while scl high
            end
            default:
            begin
                scl     = (q == 2'd1) || (q == 2'd2);
                sda_low = byte_out && !ack_slot && !sh[7];
            end
        endcase
    end

    assign bits.bit_valid = tick && (q == 2'd2) && (ack_slot || state == eeprom_pkg::ST_DATA_IN);
    assign bits.bit_slot  = (state == eeprom_pkg::ST_DATA_IN) ? eeprom_pkg::SLOT_DATA
                                                             : eeprom_pkg::SLOT_ACK;
    assign bits.bit_val   = sda_in;
    assign bits.xfer_end  = (state == eeprom_pkg::ST_END);
    assign bits.xfer_op   = op_q;
    assign busy           = (state != eeprom_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* hdl/eeprom_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_cmd_decode
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic                          busy,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    eeprom_cmd_if.decode                  cmd
);

    logic accept;

    // a strobe in the cycle of cmd_valid is also dropped, busy is not up yet
    assign accept = (wr || rd) && !busy && !cmd.cmd_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            cmd.cmd_valid <= 1'b0;
        else
            cmd.cmd_valid <= accept;
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd.op                   <= wr ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ; // wr wins
            cmd.ctrl.fields.dev_code <= eeprom_pkg::DEV_CODE;
            cmd.ctrl.fields.page     <= addr[eeprom_pkg::ADDR_W-1:8];
            cmd.ctrl.fields.rnw      <= 1'b0;
            cmd.word_addr            <= addr[7:0];
            cmd.wdata                <= wdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/eeprom_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface eeprom_cmd_if;

    logic                   cmd_valid; // one cycle per accepted strobe
    eeprom_pkg::op_e        op;
    eeprom_pkg::ctrl_byte_u ctrl;      // rnw always 0 here
    logic [7:0]             word_addr;
    logic [7:0]             wdata;

    modport decode
    (
        output cmd_valid, op, ctrl, word_addr, wdata
    );

    modport execute
    (
        input cmd_valid, op, ctrl, word_addr, wdata
    );

endinterface

`default_nettype wire

/* hdl/eeprom_ctl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctl_top
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata,
    output logic                          done,
    output logic                          ack_err,
    output logic                          busy,
    output logic                          scl,
    inout  wire                           sda
);

    logic sda_low;

    eeprom_cmd_if cmd_bus ();
    eeprom_bit_if bit_bus ();

    eeprom_cmd_decode u_decode
    (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .busy  (busy),
        .addr  (addr),
        .wdata (wdata),
        .cmd   (cmd_bus.decode)
    );

    eeprom_bus_execute u_execute
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd_bus.execute),
        .bits    (bit_bus.execute),
        .busy    (busy),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_result u_result
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .bits    (bit_bus.result),
        .rdata   (rdata),
        .done    (done),
        .ack_err (ack_err)
    );

    assign sda = sda_low ? 1'b0 : 1'bz; // open drain, pulled up outside

endmodule

`default_nettype wire

/* hdl/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam logic [3:0] DEV_CODE = 4'b1010; // 24Cxx device type
    localparam int QTR = 1;                    // CLK cycles per quarter bit

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // control byte as sent on the wire, MSB first
    typedef struct packed
    {
        logic [3:0] dev_code;
        logic [2:0] page;     // address bits 10..8
        logic       rnw;
    } ctrl_fields_s;

    typedef union packed
    {
        logic [7:0]   raw;
        ctrl_fields_s fields;
    } ctrl_byte_u;

    typedef enum logic [1:0]
    {
        SLOT_ACK  = 2'd0,
        SLOT_DATA = 2'd1
    } slot_e;

    // bus sequencer states
    localparam logic [3:0] ST_IDLE    = 4'd0;
    localparam logic [3:0] ST_START   = 4'd1;
    localparam logic [3:0] ST_CTRL    = 4'd2;
    localparam logic [3:0] ST_ADDR    = 4'd3;
    localparam logic [3:0] ST_RESTART = 4'd4;
    localparam logic [3:0] ST_RDCTRL  = 4'd5;
    localparam logic [3:0] ST_DATA_IN = 4'd6;
    localparam logic [3:0] ST_WDATA   = 4'd7;
    localparam logic [3:0] ST_NACK    = 4'd8;
    localparam logic [3:0] ST_STOP    = 4'd9;
    localparam logic [3:0] ST_END     = 4'd10;

endpackage

`default_nettype wire

/* hdl/eeprom_result.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_result
(
    input  logic         CLK,
    input  logic         RESET,
    eeprom_bit_if.result bits,
    output logic [7:0]   rdata,
    output logic         done,
    output logic         ack_err
);

    logic [7:0] hold;
    logic       err_q;   // sticky, any slave nack seen

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            err_q   <= 1'b0;
            done    <= 1'b0;
            ack_err <= 1'b0;
        end
        else
        begin
            done <= bits.xfer_end;
            if (bits.xfer_end)
            begin
                ack_err <= err_q;
                err_q   <= 1'b0;   // fresh for the next transfer
            end
            else if (bits.bit_valid && bits.bit_slot == eeprom_pkg::SLOT_ACK)
                err_q <= err_q | bits.bit_val;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bits.bit_valid && bits.bit_slot == eeprom_pkg::SLOT_DATA)
            hold <= {hold[6:0], bits.bit_val}; // msb first
        if (bits.xfer_end && bits.xfer_op == eeprom_pkg::OP_READ)
            rdata <= hold;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/eeprom_pkg.sv
hdl/eeprom_cmd_if.sv
hdl/eeprom_bit_if.sv
hdl/eeprom_cmd_decode.sv
hdl/eeprom_bus_execute.sv
hdl/eeprom_result.sv
hdl/eeprom_ctl_top.sv
bench/eeprom_model.sv
bench/eeprom_ctl_assertions.sv
bench/eeprom_ctl_tb.sv
